//--- design/read_rw.sv
`timescale 1ns/1ns
`include "rw_macros.svh"

module read_rw (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 in_valid,
   input  rw_pkg::ts_t          in_ts,
   input  rw_pkg::locale_t      in_locale,
   input  rw_pkg::ttype_t       in_ttype,
   input  rw_pkg::cq_slot_t     in_cq_slot,
   output logic                 in_ready,

   input  logic                 tid_avail,
   input  rw_pkg::thread_id_t   tid_free_id,
   output logic                 tid_take,
   output logic                 tid_release,
   output rw_pkg::thread_id_t   tid_release_id,

   output logic                 arvalid,
   output logic [31:0]          araddr,
   output rw_pkg::thread_id_t   arid,
   input  logic                 arready,

   input  logic                 rvalid,
   input  rw_pkg::thread_id_t   rid,
   input  rw_pkg::line_t        rdata,
   input  rw_pkg::line_idx_t    rindex,
   output logic                 rready,

   output logic                 fifo_push,
   output rw_pkg::ts_t          push_ts,
   output rw_pkg::locale_t      push_locale,
   output rw_pkg::ttype_t       push_ttype,
   output rw_pkg::cq_slot_t     push_cq_slot,
   output rw_pkg::thread_id_t   push_thread,
   output rw_pkg::object_t      push_object,
   output rw_pkg::line_idx_t    push_cache_index,
   input  logic                 fifo_full,
   input  rw_pkg::fifo_size_t   fifo_occ,

   input  logic                 reg_wvalid,
   input  rw_pkg::reg_addr_t    reg_waddr,
   input  rw_pkg::reg_data_t    reg_wdata,
   input  logic                 reg_arvalid,
   input  rw_pkg::reg_addr_t    reg_araddr,
   output logic                 reg_rvalid,
   output rw_pkg::reg_data_t    reg_rdata
);

   // per-thread task context, valid while the line read is outstanding
   rw_pkg::ts_t      ctx_ts     [`RW_N_THREADS];
   rw_pkg::locale_t  ctx_locale [`RW_N_THREADS];
   rw_pkg::ttype_t   ctx_ttype  [`RW_N_THREADS];
   rw_pkg::cq_slot_t ctx_slot   [`RW_N_THREADS];

   rw_pkg::reg_data_t  base_addr;
   rw_pkg::fifo_size_t almost_full_thresh;
   rw_pkg::reg_data_t  dequeues_left;

   logic            admit_ok;
   logic            accept;
   rw_pkg::locale_t rsp_locale;

   assign admit_ok = in_valid & tid_avail & (fifo_occ < almost_full_thresh) &
                     (dequeues_left != '0);

   assign arvalid = admit_ok;
   assign in_ready = admit_ok & arready;
   assign accept = in_valid & in_ready;
   assign tid_take = accept;

   assign arid = tid_free_id;
   assign araddr = base_addr + (in_locale << `RW_ARSIZE);

   always_ff @(posedge clk) begin
      if (accept) begin
         ctx_ts[tid_free_id] <= in_ts;
         ctx_locale[tid_free_id] <= in_locale;
         ctx_ttype[tid_free_id] <= in_ttype;
         ctx_slot[tid_free_id] <= in_cq_slot;
      end
   end

   // response merge, rready only when the record can be written
   assign fifo_push = rvalid & ~fifo_full;
   assign rready = fifo_push;
   assign tid_release = fifo_push;
   assign tid_release_id = rid;

   assign rsp_locale = ctx_locale[rid];
   assign push_ts = ctx_ts[rid];
   assign push_locale = rsp_locale;
   assign push_ttype = ctx_ttype[rid];
   assign push_cq_slot = ctx_slot[rid];
   assign push_thread = rid;
   assign push_object = rdata[rsp_locale[3:0]*32 +: 32]; // 16 words per line
   assign push_cache_index = rindex;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_addr <= '0;
         almost_full_thresh <= '1;
         dequeues_left <= '1;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            `RW_REG_BASE_ADDR:   base_addr <= reg_wdata;
            `RW_REG_ALMOST_FULL: almost_full_thresh <= reg_wdata[`RW_OCC_W-1:0];
            `RW_REG_N_DEQUEUES:  dequeues_left <= reg_wdata;
            default: ;
         endcase
      end else if (accept) begin
         dequeues_left <= dequeues_left - 1'b1; // write wins over decrement
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            `RW_REG_BASE_ADDR:   reg_rdata <= base_addr;
            `RW_REG_ALMOST_FULL: reg_rdata <= rw_pkg::reg_data_t'(almost_full_thresh);
            `RW_REG_N_DEQUEUES:  reg_rdata <= dequeues_left;
            `RW_REG_OUT_OCC:     reg_rdata <= rw_pkg::reg_data_t'(fifo_occ);
            default:             reg_rdata <= '0;
         endcase
      end
   end

endmodule

//--- design/rw_line_mem.sv
`timescale 1ns/1ns
`include "rw_macros.svh"

module rw_line_mem (
   input  logic               clk,
   input  logic               rstn,

   input  logic               arvalid,
   input  logic [31:0]        araddr,
   input  rw_pkg::thread_id_t arid,
   output logic               arready,

   output logic               rvalid,
   output rw_pkg::thread_id_t rid,
   output rw_pkg::line_t      rdata,
   output rw_pkg::line_idx_t  rindex,
   input  logic               rready,

   input  logic               mem_wvalid,
   input  rw_pkg::line_idx_t  mem_windex,
   input  rw_pkg::line_t      mem_wdata
);

   localparam int PTR_W = $clog2(`RW_REQ_DEPTH);
   localparam int CNT_W = $clog2(`RW_REQ_DEPTH + 1);

   rw_pkg::line_t      mem   [`RW_MEM_LINES];
   rw_pkg::thread_id_t q_id  [`RW_REQ_DEPTH];
   rw_pkg::line_idx_t  q_idx [`RW_REQ_DEPTH];
   logic [1:0]         q_wait [`RW_REQ_DEPTH]; // cycles left before presenting

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [3:0]       lfsr;
   logic             req_fire;
   logic             rsp_fire;

   assign arready = (count < CNT_W'(`RW_REQ_DEPTH));
   assign req_fire = arvalid & arready;
   assign rsp_fire = rvalid & rready;

   // head stays presented until taken, its wait count never rises again
   assign rvalid = (count != '0) && (q_wait[rd_ptr] == 2'd0);
   assign rid = q_id[rd_ptr];
   assign rindex = q_idx[rd_ptr];
   assign rdata = mem[q_idx[rd_ptr]];

   always_ff @(posedge clk) begin
      if (mem_wvalid) begin
         mem[mem_windex] <= mem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `RW_REQ_DEPTH; i++) begin
         if (q_wait[i] != 2'd0) begin
            q_wait[i] <= q_wait[i] - 2'd1;
         end
      end
      if (req_fire) begin
         q_id[wr_ptr] <= arid;
         q_idx[wr_ptr] <= araddr[6 +: `RW_LINE_IDX_W]; // 64-byte lines
         q_wait[wr_ptr] <= 2'd2 + {1'b0, lfsr[0]}; // two or three cycles
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         lfsr <= 4'b1001;
      end else begin
         lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
         if (req_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rsp_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({req_fire, rsp_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- design/rw_macros.svh
`ifndef RW_MACROS_SVH
`define RW_MACROS_SVH

// thread pool
`define RW_N_THREADS 8
`define RW_TID_W 3

// line memory geometry
`define RW_LINE_W 512
`define RW_MEM_LINES 64
`define RW_LINE_IDX_W 6
`define RW_REQ_DEPTH 4

// log2 of object size in bytes
`define RW_ARSIZE 2

// output fifo
`define RW_OUT_DEPTH 16
`define RW_OCC_W 5

// register map
`define RW_REG_BASE_ADDR 8'h10
`define RW_REG_ALMOST_FULL 8'h14
`define RW_REG_N_DEQUEUES 8'h18
`define RW_REG_OUT_OCC 8'h1c

`endif

//--- design/rw_pkg.sv
`include "rw_macros.svh"

package rw_pkg;

   // task descriptor fields
   typedef logic [31:0] ts_t;
   typedef logic [31:0] locale_t;
   typedef logic [3:0] ttype_t;
   typedef logic [7:0] cq_slot_t;

   typedef logic [`RW_TID_W-1:0] thread_id_t;

   // memory side
   typedef logic [31:0] object_t;
   typedef logic [`RW_LINE_W-1:0] line_t;
   typedef logic [`RW_LINE_IDX_W-1:0] line_idx_t;

   typedef logic [`RW_OCC_W-1:0] fifo_size_t;

   // register port
   typedef logic [7:0] reg_addr_t;
   typedef logic [31:0] reg_data_t;

endpackage

//--- design/rw_read_top.sv
`timescale 1ns/1ns

module rw_read_top (
   input  logic               clk,
   input  logic               rstn,

   input  logic               in_valid,
   input  rw_pkg::ts_t        in_ts,
   input  rw_pkg::locale_t    in_locale,
   input  rw_pkg::ttype_t     in_ttype,
   input  rw_pkg::cq_slot_t   in_cq_slot,
   output logic               in_ready,

   output logic               out_valid,
   output rw_pkg::ts_t        out_ts,
   output rw_pkg::locale_t    out_locale,
   output rw_pkg::ttype_t     out_ttype,
   output rw_pkg::cq_slot_t   out_cq_slot,
   output rw_pkg::thread_id_t out_thread,
   output rw_pkg::object_t    out_object,
   output rw_pkg::line_idx_t  out_cache_index,
   input  logic               out_ready,

   input  logic               reg_wvalid,
   input  rw_pkg::reg_addr_t  reg_waddr,
   input  rw_pkg::reg_data_t  reg_wdata,
   input  logic               reg_arvalid,
   input  rw_pkg::reg_addr_t  reg_araddr,
   output logic               reg_rvalid,
   output rw_pkg::reg_data_t  reg_rdata,

   input  logic               mem_wvalid,
   input  rw_pkg::line_idx_t  mem_windex,
   input  rw_pkg::line_t      mem_wdata
);

   logic               tid_avail;
   rw_pkg::thread_id_t tid_free_id;
   logic               tid_take;
   logic               tid_release;
   rw_pkg::thread_id_t tid_release_id;

   logic               arvalid;
   logic [31:0]        araddr;
   rw_pkg::thread_id_t arid;
   logic               arready;
   logic               rvalid;
   rw_pkg::thread_id_t rid;
   rw_pkg::line_t      rdata;
   rw_pkg::line_idx_t  rindex;
   logic               rready;

   logic               fifo_push;
   rw_pkg::ts_t        push_ts;
   rw_pkg::locale_t    push_locale;
   rw_pkg::ttype_t     push_ttype;
   rw_pkg::cq_slot_t   push_cq_slot;
   rw_pkg::thread_id_t push_thread;
   rw_pkg::object_t    push_object;
   rw_pkg::line_idx_t  push_cache_index;
   logic               fifo_full;
   rw_pkg::fifo_size_t fifo_occ;

   read_rw ctrl_i (
      .clk, .rstn,
      .in_valid, .in_ts, .in_locale, .in_ttype, .in_cq_slot, .in_ready,
      .tid_avail, .tid_free_id, .tid_take, .tid_release, .tid_release_id,
      .arvalid, .araddr, .arid, .arready,
      .rvalid, .rid, .rdata, .rindex, .rready,
      .fifo_push, .push_ts, .push_locale, .push_ttype, .push_cq_slot,
      .push_thread, .push_object, .push_cache_index, .fifo_full, .fifo_occ,
      .reg_wvalid, .reg_waddr, .reg_wdata, .reg_arvalid, .reg_araddr,
      .reg_rvalid, .reg_rdata
   );

   thread_pool pool_i (
      .clk, .rstn,
      .take(tid_take),
      .release_req(tid_release),
      .release_id(tid_release_id),
      .avail(tid_avail),
      .free_id(tid_free_id)
   );

   rw_line_mem mem_i (
      .clk, .rstn,
      .arvalid, .araddr, .arid, .arready,
      .rvalid, .rid, .rdata, .rindex, .rready,
      .mem_wvalid, .mem_windex, .mem_wdata
   );

   task_out_fifo out_fifo_i (
      .clk, .rstn,
      .push(fifo_push),
      .in_ts(push_ts), .in_locale(push_locale), .in_ttype(push_ttype),
      .in_cq_slot(push_cq_slot), .in_thread(push_thread),
      .in_object(push_object), .in_cache_index(push_cache_index),
      .pop(out_ready),
      .valid(out_valid), .full(fifo_full), .occ(fifo_occ),
      .out_ts, .out_locale, .out_ttype, .out_cq_slot,
      .out_thread, .out_object, .out_cache_index
   );

endmodule

//--- design/task_out_fifo.sv
`timescale 1ns/1ns
`include "rw_macros.svh"

module task_out_fifo (
   input  logic               clk,
   input  logic               rstn,

   input  logic               push,
   input  rw_pkg::ts_t        in_ts,
   input  rw_pkg::locale_t    in_locale,
   input  rw_pkg::ttype_t     in_ttype,
   input  rw_pkg::cq_slot_t   in_cq_slot,
   input  rw_pkg::thread_id_t in_thread,
   input  rw_pkg::object_t    in_object,
   input  rw_pkg::line_idx_t  in_cache_index,
   input  logic               pop,

   output logic               valid,
   output logic               full,
   output rw_pkg::fifo_size_t occ,
   output rw_pkg::ts_t        out_ts,
   output rw_pkg::locale_t    out_locale,
   output rw_pkg::ttype_t     out_ttype,
   output rw_pkg::cq_slot_t   out_cq_slot,
   output rw_pkg::thread_id_t out_thread,
   output rw_pkg::object_t    out_object,
   output rw_pkg::line_idx_t  out_cache_index
);

   localparam int PTR_W = $clog2(`RW_OUT_DEPTH);

   rw_pkg::ts_t        b_ts     [`RW_OUT_DEPTH];
   rw_pkg::locale_t    b_locale [`RW_OUT_DEPTH];
   rw_pkg::ttype_t     b_ttype  [`RW_OUT_DEPTH];
   rw_pkg::cq_slot_t   b_slot   [`RW_OUT_DEPTH];
   rw_pkg::thread_id_t b_thread [`RW_OUT_DEPTH];
   rw_pkg::object_t    b_object [`RW_OUT_DEPTH];
   rw_pkg::line_idx_t  b_index  [`RW_OUT_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign valid = (occ != '0);
   assign full = (occ == rw_pkg::fifo_size_t'(`RW_OUT_DEPTH));
   assign do_push = push & ~full;
   assign do_pop = pop & valid;

   assign out_ts = b_ts[rd_ptr];
   assign out_locale = b_locale[rd_ptr];
   assign out_ttype = b_ttype[rd_ptr];
   assign out_cq_slot = b_slot[rd_ptr];
   assign out_thread = b_thread[rd_ptr];
   assign out_object = b_object[rd_ptr];
   assign out_cache_index = b_index[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         b_ts[wr_ptr] <= in_ts;
         b_locale[wr_ptr] <= in_locale;
         b_ttype[wr_ptr] <= in_ttype;
         b_slot[wr_ptr] <= in_cq_slot;
         b_thread[wr_ptr] <= in_thread;
         b_object[wr_ptr] <= in_object;
         b_index[wr_ptr] <= in_cache_index;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         occ <= occ + do_push - do_pop; // pointers wrap, depth is a power of two
      end
   end

endmodule

//--- design/thread_pool.sv
`timescale 1ns/1ns
`include "rw_macros.svh"

module thread_pool (
   input  logic               clk,
   input  logic               rstn,
   input  logic               take,
   input  logic               release_req,
   input  rw_pkg::thread_id_t release_id,
   output logic               avail,
   output rw_pkg::thread_id_t free_id
);

   logic [`RW_N_THREADS-1:0] free_map;
   logic [`RW_N_THREADS-1:0] take_mask;
   logic [`RW_N_THREADS-1:0] rel_mask;

   assign avail = |free_map;

   // lowest free id wins
   always_comb begin
      free_id = '0;
      for (int i = `RW_N_THREADS - 1; i >= 0; i--) begin
         if (free_map[i]) begin
            free_id = rw_pkg::thread_id_t'(i);
         end
      end
   end

   always_comb begin
      take_mask = '0;
      rel_mask = '0;
      if (take) begin
         take_mask[free_id] = 1'b1;
      end
      if (release_req) begin
         rel_mask[release_id] = 1'b1;
      end
   end

   // a released id is in flight, so it never collides with the one taken
   always_ff @(posedge clk) begin
      if (!rstn) begin
         free_map <= '1;
      end else begin
         free_map <= (free_map & ~take_mask) | rel_mask;
      end
   end

endmodule

//--- verification/rw_read_tb.sv
`timescale 1ns/1ns
`include "rw_macros.svh"

module rw_read_tb;

   logic               clk;
   logic               rstn;
   logic               in_valid;
   rw_pkg::ts_t        in_ts;
   rw_pkg::locale_t    in_locale;
   rw_pkg::ttype_t     in_ttype;
   rw_pkg::cq_slot_t   in_cq_slot;
   logic               in_ready;
   logic               out_valid;
   rw_pkg::ts_t        out_ts;
   rw_pkg::locale_t    out_locale;
   rw_pkg::ttype_t     out_ttype;
   rw_pkg::cq_slot_t   out_cq_slot;
   rw_pkg::thread_id_t out_thread;
   rw_pkg::object_t    out_object;
   rw_pkg::line_idx_t  out_cache_index;
   logic               out_ready;
   logic               reg_wvalid;
   rw_pkg::reg_addr_t  reg_waddr;
   rw_pkg::reg_data_t  reg_wdata;
   logic               reg_arvalid;
   rw_pkg::reg_addr_t  reg_araddr;
   logic               reg_rvalid;
   rw_pkg::reg_data_t  reg_rdata;
   logic               mem_wvalid;
   rw_pkg::line_idx_t  mem_windex;
   rw_pkg::line_t      mem_wdata;

   // reference state, all of it updated at rising edges by the monitor
   rw_pkg::line_t            mirror [`RW_MEM_LINES];
   logic [116:0]             exp_q [$];
   rw_pkg::thread_id_t       inflight_q [$];
   logic [`RW_N_THREADS-1:0] busy;
   int                       model_occ;
   logic [4:0]               model_thresh;
   logic [31:0]              model_budget;
   logic [31:0]              model_base;
   int                       pop_count;
   int                       error_count;
   logic [31:0]              rnd_state;
   logic [31:0]              stall_state;
   int                       ready_mode; // 0 always ready, 1 random stalls, 2 held low

   rw_read_top dut_i (
      .clk, .rstn,
      .in_valid, .in_ts, .in_locale, .in_ttype, .in_cq_slot, .in_ready,
      .out_valid, .out_ts, .out_locale, .out_ttype, .out_cq_slot,
      .out_thread, .out_object, .out_cache_index, .out_ready,
      .reg_wvalid, .reg_waddr, .reg_wdata, .reg_arvalid, .reg_araddr,
      .reg_rvalid, .reg_rdata,
      .mem_wvalid, .mem_windex, .mem_wdata
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // expected {line index, object} for a locale
   function automatic logic [37:0] ref_lookup(input logic [31:0] base, input logic [31:0] locale);
      logic [31:0] addr;
      int          line;
      int          word;
      addr = base + (locale << `RW_ARSIZE);
      line = (addr / 64) % `RW_MEM_LINES;
      word = locale % 16;
      return {rw_pkg::line_idx_t'(line), mirror[line][word*32 +: 32]};
   endfunction

   function automatic int lowest_free(input logic [`RW_N_THREADS-1:0] map);
      for (int i = 0; i < `RW_N_THREADS; i++) begin
         if (!map[i]) return i;
      end
      return -1;
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_now(input string why);
      error_count++;
      $display("%s, at %0t ns", why, $time);
      $display("Test failed");
      $fatal(1, "%s", why);
   endtask

   always @(posedge clk) begin : monitor
      int                 thr;
      logic               exp_ready;
      logic               pop_fire;
      logic [37:0]        lk;
      rw_pkg::ts_t        e_ts;
      rw_pkg::locale_t    e_loc;
      rw_pkg::ttype_t     e_tt;
      rw_pkg::cq_slot_t   e_slot;
      rw_pkg::thread_id_t e_thr;
      rw_pkg::object_t    e_obj;
      rw_pkg::line_idx_t  e_idx;
      if (rstn) begin
         thr = lowest_free(busy);
         // memory queue holds exactly the in-flight reads
         exp_ready = in_valid && (thr >= 0) && (model_occ < model_thresh) &&
                     (model_budget != 0) && (inflight_q.size() < `RW_REQ_DEPTH);
         check("in_ready", in_ready, exp_ready);
         check("out_valid", out_valid, model_occ != 0);
         pop_fire = out_ready && (model_occ != 0);
         if (in_valid && in_ready) begin
            lk = ref_lookup(model_base, in_locale);
            exp_q.push_back({in_ts, in_locale, in_ttype, in_cq_slot,
                             rw_pkg::thread_id_t'(thr), lk[31:0], lk[37:32]});
            inflight_q.push_back(rw_pkg::thread_id_t'(thr));
            busy[thr] = 1'b1;
         end
         if (dut_i.fifo_push) begin
            if (inflight_q.size() == 0 || model_occ == `RW_OUT_DEPTH) begin
               fail_now("FIFO push seen with no outstanding read or with the FIFO full");
            end else begin
               busy[inflight_q.pop_front()] = 1'b0; // thread freed on push
               model_occ++;
            end
         end
         if (pop_fire) begin
            if (exp_q.size() == 0) begin
               fail_now("a record left the FIFO while none was expected");
            end else begin
               {e_ts, e_loc, e_tt, e_slot, e_thr, e_obj, e_idx} = exp_q.pop_front();
               check("out_ts", out_ts, e_ts);
               check("out_locale", out_locale, e_loc);
               check("out_ttype", out_ttype, e_tt);
               check("out_cq_slot", out_cq_slot, e_slot);
               check("out_thread", out_thread, e_thr);
               check("out_object", out_object, e_obj);
               check("out_cache_index", out_cache_index, e_idx);
               model_occ--;
               pop_count++;
            end
         end
         if (reg_wvalid) begin
            case (reg_waddr)
               `RW_REG_BASE_ADDR:   model_base = reg_wdata;
               `RW_REG_ALMOST_FULL: model_thresh = reg_wdata[4:0];
               `RW_REG_N_DEQUEUES:  model_budget = reg_wdata;
               default: ;
            endcase
         end else if (in_valid && in_ready) begin
            model_budget = model_budget - 1;
         end
      end
   end

   // output back-pressure
   initial begin
      forever begin
         @(negedge clk);
         if (ready_mode == 1) begin
            stall_state = lcg_next(stall_state);
            out_ready = stall_state[28];
         end else begin
            out_ready = (ready_mode == 0);
         end
      end
   end

   // driver tasks enter and leave at a falling edge
   task automatic write_reg(input rw_pkg::reg_addr_t addr, input rw_pkg::reg_data_t data);
      reg_wvalid = 1'b1;
      reg_waddr = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
   endtask

   task automatic read_reg(input rw_pkg::reg_addr_t addr, input logic [31:0] exp_val);
      reg_arvalid = 1'b1;
      reg_araddr = addr;
      @(negedge clk);
      reg_arvalid = 1'b0;
      check("reg_rvalid", reg_rvalid, 1'b1);
      check("reg_rdata", reg_rdata, exp_val);
   endtask

   task automatic preload_lines();
      rw_pkg::line_t line;
      for (int i = 0; i < `RW_MEM_LINES; i++) begin
         for (int w = 0; w < 16; w++) begin
            rnd_state = lcg_next(rnd_state);
            line[w*32 +: 32] = rnd_state;
         end
         mirror[i] = line;
         mem_wvalid = 1'b1;
         mem_windex = rw_pkg::line_idx_t'(i);
         mem_wdata = line;
         @(negedge clk);
      end
      mem_wvalid = 1'b0;
   endtask

   task automatic offer_task(input int max_cycles, output logic taken);
      int n;
      taken = 1'b0;
      n = 0;
      rnd_state = lcg_next(rnd_state);
      in_ts = rnd_state;
      rnd_state = lcg_next(rnd_state);
      in_locale = rnd_state;
      rnd_state = lcg_next(rnd_state);
      in_ttype = rnd_state[19:16];
      in_cq_slot = rnd_state[31:24];
      in_valid = 1'b1;
      while (!taken && n < max_cycles) begin
         @(posedge clk);
         taken = in_ready;
         n++;
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic send_task();
      logic taken;
      offer_task(500, taken);
      if (!taken) fail_now("a task was not accepted within 500 cycles");
   endtask

   // reads_only waits for in-flight reads, otherwise for every record to leave
   task automatic wait_quiet(input bit reads_only, input int max_cycles);
      int n;
      n = 0;
      while ((reads_only ? inflight_q.size() : exp_q.size()) != 0 && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if ((reads_only ? inflight_q.size() : exp_q.size()) != 0) begin
         fail_now("timed out waiting for outstanding tasks to finish");
      end
   endtask

   initial begin
      logic taken;
      int   n_taken;
      int   reuse_start;
      rnd_state = 32'hed88c94b;
      stall_state = lcg_next(32'hed88c94b);
      in_valid = 1'b0;
      in_ts = '0;
      in_locale = '0;
      in_ttype = '0;
      in_cq_slot = '0;
      out_ready = 1'b1;
      reg_wvalid = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      mem_wvalid = 1'b0;
      mem_windex = '0;
      mem_wdata = '0;
      busy = '0;
      model_occ = 0;
      model_thresh = '1;
      model_budget = '1;
      model_base = '0;
      pop_count = 0;
      error_count = 0;
      ready_mode = 0;
      rstn = 1'b0;
      repeat (8) @(negedge clk);
      rstn = 1'b1;
      check("out_valid after reset", out_valid, 1'b0);
      check("reg_rvalid after reset", reg_rvalid, 1'b0);
      preload_lines();
      rnd_state = lcg_next(rnd_state);
      write_reg(`RW_REG_BASE_ADDR, rnd_state & 32'h0000_0fc0); // line aligned

      // steady flow, then random output stalls
      repeat (40) send_task();
      wait_quiet(0, 2000);
      ready_mode = 1;
      repeat (60) send_task();
      wait_quiet(0, 4000);

      // almost-full threshold with the output blocked
      ready_mode = 2;
      write_reg(`RW_REG_ALMOST_FULL, 32'd3);
      n_taken = 0;
      repeat (10) begin
         offer_task(20, taken);
         if (taken) n_taken++;
      end
      wait_quiet(1, 500);
      check("records held in FIFO", model_occ, n_taken);
      check("threshold reached", model_occ >= 3, 1'b1);
      read_reg(`RW_REG_OUT_OCC, n_taken);
      read_reg(`RW_REG_ALMOST_FULL, 32'd3);
      write_reg(`RW_REG_ALMOST_FULL, 32'd31);
      ready_mode = 0;
      wait_quiet(0, 2000);

      // dequeue budget
      write_reg(`RW_REG_N_DEQUEUES, 32'd5);
      n_taken = 0;
      repeat (8) begin
         offer_task(30, taken);
         if (taken) n_taken++;
      end
      check("tasks accepted on budget", n_taken, 5);
      wait_quiet(0, 2000);
      read_reg(`RW_REG_N_DEQUEUES, 32'd0);
      write_reg(`RW_REG_N_DEQUEUES, 32'hffff_ffff);

      // thread reuse under stalls with a new base
      rnd_state = lcg_next(rnd_state);
      write_reg(`RW_REG_BASE_ADDR, rnd_state & 32'h0000_ffc0);
      ready_mode = 1;
      reuse_start = pop_count;
      repeat (30) send_task();
      wait_quiet(0, 4000);
      check("records out in reuse phase", pop_count - reuse_start, 30);

      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
design/rw_pkg.sv
design/read_rw.sv
design/thread_pool.sv
design/rw_line_mem.sv
design/task_out_fifo.sv
design/rw_read_top.sv
verification/rw_read_tb.sv
